//--- rtl/regex_pkg.sv
`default_nettype none

package regex_pkg;

    // character and memory geometry
    localparam int CHARACTER_WIDTH   = 8;
    localparam int MEMORY_WIDTH      = 16;
    localparam int MEMORY_ADDR_WIDTH = 11;
    // one select bit picks a character inside a word
    localparam int C_ADDR_OFFSET     = 1;

    // program lives at word addresses 0..255, pc equals word address
    localparam int PC_WIDTH          = 8;
    localparam int REG_WIDTH         = 32;

    // thread queues
    localparam int FIFO_DEPTH        = 4;
    localparam int FIFO_COUNT_WIDTH  = 3;

    // opcode sits in instruction bits 15..13, operand in bits 7..0
    typedef enum logic [2:0] {
        OP_MATCH  = 3'd0,
        OP_JMP    = 3'd1,
        OP_SPLIT  = 3'd2,
        OP_ACCEPT = 3'd3
    } opcode_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH_FIRST,
        S_EXEC,
        S_FETCH_NEXT,
        S_NO_FETCH_NEXT,
        S_ACCEPTED,
        S_REJECTED,
        S_ERROR
    } state_e;

endpackage

`default_nettype wire

//--- rtl/pc_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module pc_fifo
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          push,
    input  logic [regex_pkg::PC_WIDTH-1:0] push_pc,
    input  logic                          pop,
    output logic [regex_pkg::PC_WIDTH-1:0] pop_pc,
    output logic                          empty,
    output logic                          full
);

    logic [regex_pkg::PC_WIDTH-1:0]         entries [regex_pkg::FIFO_DEPTH];
    logic [$clog2(regex_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(regex_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [regex_pkg::FIFO_COUNT_WIDTH-1:0] count;
    logic                                   do_push;
    logic                                   do_pop;

    assign empty = (count == '0);
    assign full  = (count == regex_pkg::FIFO_COUNT_WIDTH'(regex_pkg::FIFO_DEPTH));
    // a push into a full queue is dropped, the caller flags it
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign pop_pc  = entries[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            entries[wr_ptr] <= push_pc;
    end

endmodule

`default_nettype wire

//--- rtl/memory_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module memory_arbiter
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   cc_req,
    input  logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] cc_addr,
    input  logic                                   instr_req,
    input  logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] instr_addr,
    output logic                                   cc_grant,
    output logic                                   instr_grant,
    output logic                                   cc_data_valid,
    output logic                                   instr_data_valid,
    output logic                                   memory_valid,
    output logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] memory_addr,
    input  logic                                   memory_ready
);

    // fsm wins, basic block only gets the port when the fsm is quiet
    assign memory_valid = cc_req || instr_req;
    assign memory_addr  = cc_req ? cc_addr : instr_addr;
    assign cc_grant     = cc_req && memory_ready;
    assign instr_grant  = instr_req && !cc_req && memory_ready;

    // remember who owned the granted request, data arrives one cycle later
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cc_data_valid    <= 1'b0;
            instr_data_valid <= 1'b0;
        end
        else
        begin
            cc_data_valid    <= cc_grant;
            instr_data_valid <= instr_grant;
        end
    end

endmodule

`default_nettype wire

//--- rtl/basic_block.sv
`timescale 1ns/100ps
`default_nettype none

module basic_block
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   flush,
    input  logic                                   bb_go,
    input  logic                                   inject_start,
    input  logic [regex_pkg::CHARACTER_WIDTH-1:0]  cur_cc,
    input  logic                                   cur_is_even_character,
    output logic                                   instr_req,
    output logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] instr_addr,
    input  logic                                   instr_grant,
    input  logic                                   instr_data_valid,
    input  logic [regex_pkg::MEMORY_WIDTH-1:0]     memory_data,
    output logic                                   any_bb_running,
    output logic                                   any_bb_accept,
    output logic                                   all_bb_full
);

    // busy holds a live thread in pc, waiting means its fetch was granted
    logic                                  busy;
    logic                                  waiting;
    logic [regex_pkg::PC_WIDTH-1:0]        pc;
    logic                                  execute;
    regex_pkg::opcode_e                    opcode;
    logic [regex_pkg::CHARACTER_WIDTH-1:0] instr_char;
    logic [regex_pkg::PC_WIDTH-1:0]        instr_target;

    // queue ports seen as current / next character
    logic                           cur_push;
    logic [regex_pkg::PC_WIDTH-1:0] cur_push_pc;
    logic                           nxt_push;
    logic [regex_pkg::PC_WIDTH-1:0] nxt_push_pc;
    logic                           cur_pop;
    logic [regex_pkg::PC_WIDTH-1:0] cur_pop_pc;
    logic                           cur_empty;
    logic                           cur_full;
    logic                           nxt_full;

    // physical queues
    logic                           even_push;
    logic [regex_pkg::PC_WIDTH-1:0] even_push_pc;
    logic                           even_pop;
    logic [regex_pkg::PC_WIDTH-1:0] even_pop_pc;
    logic                           even_empty;
    logic                           even_full;
    logic                           odd_push;
    logic [regex_pkg::PC_WIDTH-1:0] odd_push_pc;
    logic                           odd_pop;
    logic [regex_pkg::PC_WIDTH-1:0] odd_pop_pc;
    logic                           odd_empty;
    logic                           odd_full;

    assign opcode       = regex_pkg::opcode_e'(memory_data[regex_pkg::MEMORY_WIDTH-1 -: 3]);
    assign instr_char   = memory_data[regex_pkg::CHARACTER_WIDTH-1:0];
    assign instr_target = memory_data[regex_pkg::PC_WIDTH-1:0];
    assign execute      = waiting && instr_data_valid;

    // parity picks which physical queue is current
    assign cur_empty  = cur_is_even_character ? even_empty  : odd_empty;
    assign cur_full   = cur_is_even_character ? even_full   : odd_full;
    assign nxt_full   = cur_is_even_character ? odd_full    : even_full;
    assign cur_pop_pc = cur_is_even_character ? even_pop_pc : odd_pop_pc;

    // fetch for the live thread, or pop a new one in the same cycle as its grant
    assign instr_req  = bb_go && !waiting && (busy || !cur_empty);
    assign instr_addr = {{(regex_pkg::MEMORY_ADDR_WIDTH - regex_pkg::PC_WIDTH){1'b0}},
                         busy ? pc : cur_pop_pc};
    assign cur_pop    = instr_grant && !busy;

    always_comb
    begin
        // start pc is word 0
        cur_push      = inject_start;
        cur_push_pc   = '0;
        nxt_push      = 1'b0;
        nxt_push_pc   = pc + 1'b1;
        any_bb_accept = 1'b0;
        if (execute)
        begin
            case (opcode)
                regex_pkg::OP_MATCH:
                    nxt_push = (instr_char == cur_cc);
                regex_pkg::OP_SPLIT:
                begin
                    // target waits on this character, pc+1 carries on here
                    cur_push    = 1'b1;
                    cur_push_pc = instr_target;
                end
                regex_pkg::OP_ACCEPT:
                    any_bb_accept = 1'b1;
                default:
                    ;
            endcase
        end
    end

    assign even_push    = cur_is_even_character ? cur_push    : nxt_push;
    assign even_push_pc = cur_is_even_character ? cur_push_pc : nxt_push_pc;
    assign odd_push     = cur_is_even_character ? nxt_push    : cur_push;
    assign odd_push_pc  = cur_is_even_character ? nxt_push_pc : cur_push_pc;
    assign even_pop     = cur_is_even_character && cur_pop;
    assign odd_pop      = !cur_is_even_character && cur_pop;

    assign all_bb_full    = (cur_push && cur_full) || (nxt_push && nxt_full);
    assign any_bb_running = busy || !cur_empty;

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            busy    <= 1'b0;
            waiting <= 1'b0;
        end
        else if (instr_grant)
        begin
            busy    <= 1'b1;
            waiting <= 1'b1;
        end
        else if (execute)
        begin
            waiting <= 1'b0;
            // jmp and split keep the thread, the rest end it
            busy    <= (opcode == regex_pkg::OP_JMP) || (opcode == regex_pkg::OP_SPLIT);
        end
    end

    always_ff @(posedge clk)
    begin
        if (cur_pop)
            pc <= cur_pop_pc;
        else if (execute && opcode == regex_pkg::OP_JMP)
            pc <= instr_target;
        else if (execute && opcode == regex_pkg::OP_SPLIT)
            pc <= pc + 1'b1;
    end

    pc_fifo queue_even
    (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .push    (even_push),
        .push_pc (even_push_pc),
        .pop     (even_pop),
        .pop_pc  (even_pop_pc),
        .empty   (even_empty),
        .full    (even_full)
    );

    pc_fifo queue_odd
    (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .push    (odd_push),
        .push_pc (odd_push_pc),
        .pop     (odd_pop),
        .pop_pc  (odd_pop_pc),
        .empty   (odd_empty),
        .full    (odd_full)
    );

endmodule

`default_nettype wire

//--- rtl/regex_control_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module regex_control_fsm
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   valid,
    input  logic [regex_pkg::REG_WIDTH-1:0]        start_cc_pointer,
    input  logic [regex_pkg::REG_WIDTH-1:0]        end_cc_pointer,
    output logic                                   ready,
    output logic                                   done,
    output logic                                   accept,
    output logic                                   error,
    output logic                                   cc_req,
    output logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] cc_addr,
    input  logic                                   cc_grant,
    input  logic [regex_pkg::MEMORY_WIDTH-1:0]     memory_data,
    input  logic                                   any_bb_running,
    input  logic                                   any_bb_accept,
    input  logic                                   all_bb_full,
    output logic [regex_pkg::CHARACTER_WIDTH-1:0]  cur_cc,
    output logic                                   cur_is_even_character,
    output logic                                   bb_go,
    output logic                                   inject_start,
    output logic                                   flush
);

    regex_pkg::state_e                    state;
    regex_pkg::state_e                    next_state;
    logic [regex_pkg::REG_WIDTH-1:0]      cc_pointer;
    logic [regex_pkg::REG_WIDTH-1:0]      next_cc_pointer;
    logic [regex_pkg::REG_WIDTH-1:0]      cc_pointer_inc;
    logic [regex_pkg::MEMORY_WIDTH-1:0]   cc_word;
    logic                                 load_word;
    logic                                 next_is_even;
    logic                                 at_end;
    logic                                 crosses_word;

    assign cc_pointer_inc = cc_pointer + 1'b1;
    assign at_end         = (cc_pointer == end_cc_pointer);
    // next character lives in another memory word
    assign crosses_word   = cc_pointer[regex_pkg::C_ADDR_OFFSET] !=
                            cc_pointer_inc[regex_pkg::C_ADDR_OFFSET];
    assign cur_cc = cc_word[regex_pkg::CHARACTER_WIDTH *
                            cc_pointer[regex_pkg::C_ADDR_OFFSET-1:0] +:
                            regex_pkg::CHARACTER_WIDTH];

    always_comb
    begin
        next_state      = state;
        next_cc_pointer = cc_pointer;
        next_is_even    = cur_is_even_character;
        load_word       = 1'b0;
        ready           = 1'b0;
        done            = 1'b0;
        accept          = 1'b0;
        error           = 1'b0;
        cc_req          = 1'b0;
        cc_addr         = start_cc_pointer[regex_pkg::C_ADDR_OFFSET +:
                                           regex_pkg::MEMORY_ADDR_WIDTH];
        bb_go           = 1'b0;
        inject_start    = 1'b0;
        flush           = 1'b0;
        case (state)
            regex_pkg::S_IDLE:
            begin
                // keep asking for the first word so a run starts on the grant
                cc_req = 1'b1;
                ready  = cc_grant;
                if (valid && cc_grant)
                begin
                    next_state      = regex_pkg::S_FETCH_FIRST;
                    next_cc_pointer = start_cc_pointer;
                end
            end
            regex_pkg::S_FETCH_FIRST:
            begin
                load_word    = 1'b1;
                inject_start = 1'b1;
                next_state   = regex_pkg::S_EXEC;
            end
            regex_pkg::S_EXEC:
            begin
                bb_go = 1'b1;
                if (any_bb_accept)
                    next_state = regex_pkg::S_ACCEPTED;
                else if (all_bb_full)
                    next_state = regex_pkg::S_ERROR;
                else if (!any_bb_running && at_end)
                    next_state = regex_pkg::S_REJECTED;
                else if (!any_bb_running && crosses_word)
                begin
                    cc_req  = 1'b1;
                    cc_addr = cc_pointer_inc[regex_pkg::C_ADDR_OFFSET +:
                                             regex_pkg::MEMORY_ADDR_WIDTH];
                    // hold here while the memory stalls
                    if (cc_grant)
                    begin
                        next_state      = regex_pkg::S_FETCH_NEXT;
                        next_cc_pointer = cc_pointer_inc;
                        next_is_even    = !cur_is_even_character;
                    end
                end
                else if (!any_bb_running)
                begin
                    next_state      = regex_pkg::S_NO_FETCH_NEXT;
                    next_cc_pointer = cc_pointer_inc;
                    next_is_even    = !cur_is_even_character;
                end
            end
            regex_pkg::S_FETCH_NEXT:
            begin
                load_word = 1'b1;
                // no thread waiting on the new character means no match
                next_state = any_bb_running ? regex_pkg::S_EXEC : regex_pkg::S_REJECTED;
            end
            regex_pkg::S_NO_FETCH_NEXT:
            begin
                // word already held, threads may start right away
                bb_go      = 1'b1;
                next_state = any_bb_running ? regex_pkg::S_EXEC : regex_pkg::S_REJECTED;
            end
            regex_pkg::S_ACCEPTED:
            begin
                done         = 1'b1;
                accept       = 1'b1;
                flush        = 1'b1;
                next_is_even = 1'b1;
                next_state   = regex_pkg::S_IDLE;
            end
            regex_pkg::S_REJECTED:
            begin
                done         = 1'b1;
                flush        = 1'b1;
                next_is_even = 1'b1;
                next_state   = regex_pkg::S_IDLE;
            end
            regex_pkg::S_ERROR:
                // lost thread, only rst leaves this state
                error = 1'b1;
            default:
                next_state = regex_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state                 <= regex_pkg::S_IDLE;
            cc_pointer            <= '0;
            cur_is_even_character <= 1'b1;
        end
        else
        begin
            state                 <= next_state;
            cc_pointer            <= next_cc_pointer;
            cur_is_even_character <= next_is_even;
        end
    end

    // memory_data holds the word one cycle after the grant
    always_ff @(posedge clk)
    begin
        if (load_word)
            cc_word <= memory_data;
    end

endmodule

`default_nettype wire

//--- rtl/regex_coprocessor_top.sv
`timescale 1ns/100ps
`default_nettype none

module regex_coprocessor_top
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   memory_ready,
    output logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] memory_addr,
    input  logic [regex_pkg::MEMORY_WIDTH-1:0]     memory_data,
    output logic                                   memory_valid,
    input  logic                                   valid,
    output logic                                   ready,
    input  logic [regex_pkg::REG_WIDTH-1:0]        start_cc_pointer,
    input  logic [regex_pkg::REG_WIDTH-1:0]        end_cc_pointer,
    output logic                                   done,
    output logic                                   accept,
    output logic                                   error
);

    // fsm side of the arbiter
    logic                                   cc_req;
    logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] cc_addr;
    logic                                   cc_grant;
    // basic block side of the arbiter
    logic                                   instr_req;
    logic [regex_pkg::MEMORY_ADDR_WIDTH-1:0] instr_addr;
    logic                                   instr_grant;
    logic                                   instr_data_valid;
    // control between fsm and basic block
    logic [regex_pkg::CHARACTER_WIDTH-1:0]  cur_cc;
    logic                                   cur_is_even_character;
    logic                                   bb_go;
    logic                                   inject_start;
    logic                                   flush;
    logic                                   any_bb_running;
    logic                                   any_bb_accept;
    logic                                   all_bb_full;

    regex_control_fsm i_regex_control_fsm
    (
        .clk                   (clk),
        .rst                   (rst),
        .valid                 (valid),
        .start_cc_pointer      (start_cc_pointer),
        .end_cc_pointer        (end_cc_pointer),
        .ready                 (ready),
        .done                  (done),
        .accept                (accept),
        .error                 (error),
        .cc_req                (cc_req),
        .cc_addr               (cc_addr),
        .cc_grant              (cc_grant),
        .memory_data           (memory_data),
        .any_bb_running        (any_bb_running),
        .any_bb_accept         (any_bb_accept),
        .all_bb_full           (all_bb_full),
        .cur_cc                (cur_cc),
        .cur_is_even_character (cur_is_even_character),
        .bb_go                 (bb_go),
        .inject_start          (inject_start),
        .flush                 (flush)
    );

    memory_arbiter i_memory_arbiter
    (
        .clk              (clk),
        .rst              (rst),
        .cc_req           (cc_req),
        .cc_addr          (cc_addr),
        .instr_req        (instr_req),
        .instr_addr       (instr_addr),
        .cc_grant         (cc_grant),
        .instr_grant      (instr_grant),
        .cc_data_valid    (),
        .instr_data_valid (instr_data_valid),
        .memory_valid     (memory_valid),
        .memory_addr      (memory_addr),
        .memory_ready     (memory_ready)
    );

    basic_block i_basic_block
    (
        .clk                   (clk),
        .rst                   (rst),
        .flush                 (flush),
        .bb_go                 (bb_go),
        .inject_start          (inject_start),
        .cur_cc                (cur_cc),
        .cur_is_even_character (cur_is_even_character),
        .instr_req             (instr_req),
        .instr_addr            (instr_addr),
        .instr_grant           (instr_grant),
        .instr_data_valid      (instr_data_valid),
        .memory_data           (memory_data),
        .any_bb_running        (any_bb_running),
        .any_bb_accept         (any_bb_accept),
        .all_bb_full           (all_bb_full)
    );

endmodule

`default_nettype wire

//--- verification/regex_coprocessor_sva.sv
`timescale 1ns/100ps
`default_nettype none

module regex_coprocessor_sva
(
    input logic clk,
    input logic rst,
    input logic memory_ready,
    input logic ready,
    input logic done,
    input logic accept,
    input logic error
);

    // done marks the single cycle of S_ACCEPTED or S_REJECTED
    done_single_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held high for more than one cycle");

    accept_only_with_done: assert property (@(posedge clk) disable iff (rst) accept |-> done)
        else $error("accept high without done");

    // only rst leaves S_ERROR
    error_sticky: assert property (@(posedge clk) error |=> (error || rst))
        else $error("error dropped without rst");

    done_error_exclusive: assert property (@(posedge clk) disable iff (rst) !(done && error))
        else $error("done and error high together");

    // after reset the fsm idles and ready tracks the memory grant
    reset_quiet: assert property (@(posedge clk)
        rst |=> (!done && !error && (ready == memory_ready)))
        else $error("outputs not idle after reset");

endmodule

bind regex_coprocessor_top regex_coprocessor_sva i_regex_coprocessor_sva (.*);

`default_nettype wire

//--- verification/tb_regex_coprocessor.sv
`timescale 1ns/100ps
`default_nettype none

module tb_regex_coprocessor;

    // 3 + 3 fixed runs, 30 random runs twice and 1 error run
    localparam int NUM_RUNS        = 67;
    localparam int MAX_LEN         = 12;
    localparam int CYCLES_PER_CHAR = 8;
    // factor 4 covers back-pressure stalls
    localparam int TIMEOUT_CYCLES  = 4 * NUM_RUNS * (MAX_LEN + 1) * CYCLES_PER_CHAR;
    localparam int STR_BASE        = 1024;

    logic        clk;
    logic        rst;
    logic        memory_ready;
    logic [10:0] memory_addr;
    logic [15:0] memory_data;
    logic        memory_valid;
    logic        valid;
    logic        ready;
    logic [31:0] start_cc_pointer;
    logic [31:0] end_cc_pointer;
    logic        done;
    logic        accept;
    logic        error;

    logic [15:0] mem [2048];
    logic [7:0]  str_buf [16];
    logic [7:0]  rand_str [30][16];
    int          rand_len [30];
    int          rand_start [30];
    logic        expected_accept;
    logic        backpressure;
    logic        error_run;
    int          stall_left;
    int          cycle_count;
    int          error_count;
    int          run_count;
    int          errors_before;

    regex_coprocessor_top i_regex_coprocessor_top
    (
        .clk              (clk),
        .rst              (rst),
        .memory_ready     (memory_ready),
        .memory_addr      (memory_addr),
        .memory_data      (memory_data),
        .memory_valid     (memory_valid),
        .valid            (valid),
        .ready            (ready),
        .start_cc_pointer (start_cc_pointer),
        .end_cc_pointer   (end_cc_pointer),
        .done             (done),
        .accept           (accept),
        .error            (error)
    );

    always #2 clk = !clk;

    // word comes back one cycle after the grant
    always @(posedge clk)
    begin
        if (memory_valid && memory_ready)
            memory_data <= mem[memory_addr];
    end

    // random ready with long low stretches in back-pressure mode
    always @(posedge clk)
    begin
        #1;
        if (stall_left > 0)
        begin
            memory_ready = 1'b0;
            stall_left   = stall_left - 1;
        end
        else if (backpressure && ($urandom % 4 == 0))
        begin
            memory_ready = 1'b0;
            stall_left   = $urandom % 7;
        end
        else
            memory_ready = ($urandom % 4 != 0);
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    result_check: assert property (@(posedge clk) disable iff (rst)
        done |-> (accept == expected_accept))
    else
    begin
        error_count++;
        $display("mismatch at %0t: accept %0b, expected %0b", $time, accept, expected_accept);
    end

    no_done_on_error: assert property (@(posedge clk) disable iff (rst) error_run |-> !done)
    else
    begin
        error_count++;
        $display("done pulsed at %0t during a run that must end in error", $time);
    end

    function automatic logic [15:0] encode(input regex_pkg::opcode_e op, input logic [7:0] arg);
        return {op, 5'b00000, arg};
    endfunction

    // anchored a b* d with the d strictly before the terminator
    function automatic logic expected_match(input int len);
        int i;
        i = 1;
        if (len < 1 || str_buf[0] != "a")
            return 1'b0;
        while (i < len && str_buf[i] == "b")
            i++;
        return (i < len) && (str_buf[i] == "d");
    endfunction

    function automatic void put_byte(input int ptr, input logic [7:0] c);
        logic [31:0] p;
        p = ptr;
        if (p[0])
            mem[p[11:1]][15:8] = c;
        else
            mem[p[11:1]][7:0] = c;
    endfunction

    task automatic run_string(input int start, input int len);
        @(posedge clk);
        #1;
        for (int k = 0; k < len; k++)
            put_byte(start + k, str_buf[k]);
        // terminator character
        put_byte(start + len, 8'h00);
        expected_accept  = expected_match(len);
        start_cc_pointer = start;
        end_cc_pointer   = start + len;
        valid            = 1'b1;
        do
            @(posedge clk);
        while (!ready);
        #1;
        valid = 1'b0;
        do
            @(posedge clk);
        while (!done);
        run_count++;
    endtask

    task automatic run_text(input string text, input int start);
        for (int k = 0; k < text.len(); k++)
            str_buf[k] = text[k];
        run_string(start, text.len());
    endtask

    task automatic load_pattern_program();
        mem[0] = encode(regex_pkg::OP_MATCH, "a");
        mem[1] = encode(regex_pkg::OP_SPLIT, 8'd4);
        mem[2] = encode(regex_pkg::OP_MATCH, "b");
        mem[3] = encode(regex_pkg::OP_JMP, 8'd1);
        mem[4] = encode(regex_pkg::OP_MATCH, "d");
        mem[5] = encode(regex_pkg::OP_ACCEPT, 8'd0);
    endtask

    task automatic report(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, error_count - errors_before);
        errors_before = error_count;
    endtask

    initial
    begin
        logic got_error;
        void'($urandom(15));
        clk = 1'b0;
        rst = 1'b1;
        memory_ready = 1'b0;
        memory_data = '0;
        valid = 1'b0;
        start_cc_pointer = '0;
        end_cc_pointer = '0;
        expected_accept = 1'b0;
        backpressure = 1'b0;
        error_run = 1'b0;
        stall_left = 0;
        cycle_count = 0;
        error_count = 0;
        run_count = 0;
        errors_before = 0;
        // fill depends on every address bit
        for (int i = 0; i < 2048; i++)
            mem[i] = 16'(i * 7919) ^ 16'h9e37;
        load_pattern_program();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        run_text("ad", STR_BASE);
        run_text("abbd", STR_BASE + 16);
        run_text("abbbbbd", STR_BASE + 32);
        report(1, "fixed accepting strings");

        run_text("ab", STR_BASE);
        run_text("x", STR_BASE + 16);
        run_text("abx", STR_BASE + 32);
        report(2, "fixed rejecting strings");

        for (int r = 0; r < 30; r++)
        begin
            rand_len[r]   = 1 + ($urandom % MAX_LEN);
            rand_start[r] = STR_BASE + ($urandom % 64);
            for (int k = 0; k < rand_len[r]; k++)
            begin
                case ($urandom % 4)
                    0: rand_str[r][k] = "a";
                    1: rand_str[r][k] = "b";
                    2: rand_str[r][k] = "d";
                    default: rand_str[r][k] = "x";
                endcase
            end
            // lean toward a leading a so accepts occur
            if ($urandom % 2 == 0)
                rand_str[r][0] = "a";
            str_buf = rand_str[r];
            run_string(rand_start[r], rand_len[r]);
        end
        report(3, "random strings");

        backpressure = 1'b1;
        for (int r = 0; r < 30; r++)
        begin
            str_buf = rand_str[r];
            run_string(rand_start[r], rand_len[r]);
        end
        backpressure = 1'b0;
        report(4, "random strings under back-pressure");

        // five splits overflow the current queue
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int k = 0; k < 5; k++)
            mem[k] = encode(regex_pkg::OP_SPLIT, 8'd5);
        mem[5] = encode(regex_pkg::OP_MATCH, "a");
        mem[6] = encode(regex_pkg::OP_ACCEPT, 8'd0);
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        error_run = 1'b1;
        start_cc_pointer = STR_BASE + 200;
        end_cc_pointer = STR_BASE + 204;
        for (int k = 0; k < 4; k++)
            put_byte(STR_BASE + 200 + k, "a");
        put_byte(STR_BASE + 204, 8'h00);
        valid = 1'b1;
        do
            @(posedge clk);
        while (!ready);
        #1;
        valid = 1'b0;
        got_error = 1'b0;
        for (int k = 0; k < 200 && !got_error; k++)
        begin
            @(posedge clk);
            got_error = error;
        end
        if (!got_error)
        begin
            error_count++;
            $display("error never rose after the queue overflow");
        end
        // let the no-done assertion watch a while longer
        repeat (20) @(posedge clk);
        #1;
        error_run = 1'b0;
        rst = 1'b1;
        @(posedge clk);
        @(posedge clk);
        if (error)
        begin
            error_count++;
            $display("error still high after reset");
        end
        #1;
        rst = 1'b0;
        run_count++;
        report(5, "queue overflow error");

        $display("summary: 5 tests, %0d runs, %0d errors", run_count, error_count);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/regex_pkg.sv
rtl/pc_fifo.sv
rtl/memory_arbiter.sv
rtl/basic_block.sv
rtl/regex_control_fsm.sv
rtl/regex_coprocessor_top.sv
verification/regex_coprocessor_sva.sv
verification/tb_regex_coprocessor.sv

//--- run.sh
#!/bin/sh
# build and run the regex coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_regex_coprocessor \
    -o sim_tb_regex_coprocessor
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb_regex_coprocessor > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
